/* rtl/commit_classify.sv */
module commit_classify import trace_pkg::*; (
  input  logic            valid_i,
  input  logic            ex_valid_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [ILEN-1:0] insn_i,
  input  logic [XLEN-1:0] cause_i,
  input  priv_lvl_t       priv_lvl_i,
  input  logic            debug_mode_i,
  commit_if.src           commit_o
);

  mode_t mode;
  logic  is_irq;

  assign is_irq = cause_i[CAUSE_IRQ_BIT];

  // ------------------------------
  // event classification
  // ------------------------------
  assign commit_o.retire    = valid_i & ~ex_valid_i;
  assign commit_o.exception = valid_i & ex_valid_i & ~is_irq;
  assign commit_o.interrupt = valid_i & ex_valid_i & is_irq;

  // debug mode overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_M: mode = MODE_M;
        PRIV_LVL_S: mode = MODE_S;
        PRIV_LVL_U: mode = MODE_U;
        // reserved encoding, treat as least privileged
        default:    mode = MODE_U;
      endcase
    end
  end

  // entry is built every cycle, the queue only takes it on retire
  always_comb begin
    commit_o.entry      = '0;
    commit_o.entry.pc   = pc_i;
    commit_o.entry.insn = insn_i;
    commit_o.entry.mode = mode;
  end

endmodule

/* rtl/commit_if.sv */
interface commit_if import trace_pkg::*; ();

  // one-cycle event strobes, at most one is high per cycle
  logic         retire;
  logic         exception;
  logic         interrupt;
  // only meaningful together with retire
  trace_entry_t entry;

  modport src (
    output retire,
    output exception,
    output interrupt,
    output entry
  );

  modport queue (
    input retire,
    input entry
  );

  modport count (
    input retire,
    input exception,
    input interrupt
  );

endinterface

/* rtl/commit_trace.sv */
module commit_trace import trace_pkg::*; #(
  parameter  int unsigned NrCommitPorts = 2,
  parameter  int unsigned QueueDepth    = 4,
  localparam int unsigned PortW = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // commit ports
  input  logic [NrCommitPorts-1:0]            commit_valid_i,
  input  logic [NrCommitPorts-1:0]            commit_ex_valid_i,
  input  logic [NrCommitPorts-1:0][XLEN-1:0]  commit_pc_i,
  input  logic [NrCommitPorts-1:0][ILEN-1:0]  commit_insn_i,
  input  logic [NrCommitPorts-1:0][XLEN-1:0]  commit_cause_i,
  input  priv_lvl_t                           priv_lvl_i,
  input  logic                                debug_mode_i,
  // trace bus, always accepted
  output logic                                trace_valid_o,
  output logic [PortW-1:0]                    trace_port_o,
  output logic [XLEN-1:0]                     trace_pc_o,
  output logic [ILEN-1:0]                     trace_insn_o,
  output mode_t                               trace_mode_o,
  // counter access
  input  perf_addr_t                          perf_addr_i,
  input  logic                                perf_we_i,
  input  logic [XLEN-1:0]                     perf_wdata_i,
  output logic [XLEN-1:0]                     perf_rdata_o
);

  logic         [NrCommitPorts-1:0] pending;
  logic         [NrCommitPorts-1:0] pop;
  logic         [NrCommitPorts-1:0] drop;
  trace_entry_t [NrCommitPorts-1:0] head;
  trace_entry_t                     trace_entry;

  commit_if commit_bus [NrCommitPorts] ();

  // ------------------------------
  // per-port classify and queue
  // ------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port
    commit_classify i_classify (
      .valid_i      ( commit_valid_i[i]    ),
      .ex_valid_i   ( commit_ex_valid_i[i] ),
      .pc_i         ( commit_pc_i[i]       ),
      .insn_i       ( commit_insn_i[i]     ),
      .cause_i      ( commit_cause_i[i]    ),
      .priv_lvl_i   ( priv_lvl_i           ),
      .debug_mode_i ( debug_mode_i         ),
      .commit_o     ( commit_bus[i]        )
    );

    trace_queue #(
      .QueueDepth ( QueueDepth )
    ) i_queue (
      .clk_i     ( clk_i         ),
      .rst_ni    ( rst_ni        ),
      .commit_i  ( commit_bus[i] ),
      .pop_i     ( pop[i]        ),
      .pending_o ( pending[i]    ),
      .head_o    ( head[i]       ),
      .drop_o    ( drop[i]       )
    );
  end

  // ------------------------------
  // shared trace bus
  // ------------------------------
  trace_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .pending_i     ( pending       ),
    .head_i        ( head          ),
    .pop_o         ( pop           ),
    .trace_valid_o ( trace_valid_o ),
    .trace_port_o  ( trace_port_o  ),
    .trace_entry_o ( trace_entry   )
  );

  assign trace_pc_o   = trace_entry.pc;
  assign trace_insn_o = trace_entry.insn;
  assign trace_mode_o = trace_entry.mode;

  // ------------------------------
  // counters
  // ------------------------------
  perf_counters #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_perf_counters (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_bus   ),
    .drop_i       ( drop         ),
    .perf_addr_i  ( perf_addr_i  ),
    .perf_we_i    ( perf_we_i    ),
    .perf_wdata_i ( perf_wdata_i ),
    .perf_rdata_o ( perf_rdata_o )
  );

endmodule

/* rtl/perf_counters.sv */
module perf_counters import trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  commit_if.count                  commit_i [NrCommitPorts],
  input  logic [NrCommitPorts-1:0] drop_i,
  input  perf_addr_t               perf_addr_i,
  input  logic                     perf_we_i,
  input  logic [XLEN-1:0]          perf_wdata_i,
  output logic [XLEN-1:0]          perf_rdata_o
);

  logic [NrCommitPorts-1:0] retire_vec;
  logic [NrCommitPorts-1:0] exception_vec;
  logic [NrCommitPorts-1:0] interrupt_vec;

  logic [XLEN-1:0] cnt_q [NR_PERF_COUNTERS];
  logic [XLEN-1:0] inc   [NR_PERF_COUNTERS];

  // ------------------------------
  // gather per-port events
  // ------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_events
    assign retire_vec[i]    = commit_i[i].retire;
    assign exception_vec[i] = commit_i[i].exception;
    assign interrupt_vec[i] = commit_i[i].interrupt;

    // a queue can only drop what its own port just retired
    assert property (@(posedge clk_i) disable iff (!rst_ni) drop_i[i] |-> retire_vec[i])
      else $error("perf_counters: drop without retire on port %0d", i);
  end

  // events per cycle, one per raising port
  always_comb begin
    inc[PERF_CYCLE]     = XLEN'(1);
    inc[PERF_INSTRET]   = XLEN'($countones(retire_vec));
    inc[PERF_EXCEPTION] = XLEN'($countones(exception_vec));
    inc[PERF_INTERRUPT] = XLEN'($countones(interrupt_vec));
    inc[PERF_DROPPED]   = XLEN'($countones(drop_i));
  end

  // software write wins over the increment of the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_PERF_COUNTERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NR_PERF_COUNTERS; i++) begin
        if (perf_we_i && perf_addr_i == perf_addr_t'(i)) begin
          cnt_q[i] <= perf_wdata_i;
        end else begin
          cnt_q[i] <= cnt_q[i] + inc[i];
        end
      end
    end
  end

  // ------------------------------
  // read port
  // ------------------------------
  always_comb begin
    case (perf_addr_i)
      PERF_CYCLE:     perf_rdata_o = cnt_q[PERF_CYCLE];
      PERF_INSTRET:   perf_rdata_o = cnt_q[PERF_INSTRET];
      PERF_EXCEPTION: perf_rdata_o = cnt_q[PERF_EXCEPTION];
      PERF_INTERRUPT: perf_rdata_o = cnt_q[PERF_INTERRUPT];
      PERF_DROPPED:   perf_rdata_o = cnt_q[PERF_DROPPED];
      // unmapped
      default:        perf_rdata_o = '0;
    endcase
  end

endmodule

/* rtl/trace_arbiter.sv */
module trace_arbiter import trace_pkg::*; #(
  parameter  int unsigned NrCommitPorts = 2,
  localparam int unsigned PortW = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic         [NrCommitPorts-1:0]       pending_i,
  input  trace_entry_t [NrCommitPorts-1:0]       head_i,
  output logic         [NrCommitPorts-1:0]       pop_o,
  output logic                                   trace_valid_o,
  output logic         [PortW-1:0]               trace_port_o,
  output trace_entry_t                           trace_entry_o
);

  logic [PortW-1:0] ptr_q;
  logic [PortW-1:0] gnt_idx;
  logic             gnt_found;

  // ------------------------------
  // round-robin search
  // ------------------------------
  // first pending port at or after the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int unsigned off = 0; off < NrCommitPorts; off++) begin
      idx = (int'(ptr_q) + off) % NrCommitPorts;
      if (!gnt_found && pending_i[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = PortW'(idx);
      end
    end
  end

  // output is always consumed, so the grant pops directly
  always_comb begin
    pop_o = '0;
    if (gnt_found) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  assign trace_valid_o = gnt_found;
  assign trace_port_o  = gnt_idx;
  assign trace_entry_o = head_i[gnt_idx];

  // pointer moves past the port that just won
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_found) begin
      ptr_q <= (gnt_idx == PortW'(NrCommitPorts - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(pop_o))
    else $error("trace_arbiter: more than one queue popped");

endmodule

/* rtl/trace_pkg.sv */
package trace_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned XLEN = 64;
  localparam int unsigned ILEN = 32;

  // cause bit that separates interrupts from synchronous exceptions
  localparam int unsigned CAUSE_IRQ_BIT = 63;

  // ------------------------------
  // privilege and trace mode
  // ------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_t;

  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_M = 2'd2,
    MODE_D = 2'd3
  } mode_t;

  // one retired instruction as seen on the trace bus
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] insn;
    mode_t           mode;
  } trace_entry_t;

  // ------------------------------
  // counter map
  // ------------------------------
  typedef logic [2:0] perf_addr_t;

  localparam perf_addr_t PERF_CYCLE     = 3'd0;
  localparam perf_addr_t PERF_INSTRET   = 3'd1;
  localparam perf_addr_t PERF_EXCEPTION = 3'd2;
  localparam perf_addr_t PERF_INTERRUPT = 3'd3;
  localparam perf_addr_t PERF_DROPPED   = 3'd4;

  // number of implemented counters, addresses above read as zero
  localparam int unsigned NR_PERF_COUNTERS = 5;

endpackage

/* rtl/trace_queue.sv */
module trace_queue import trace_pkg::*; #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  commit_if.queue      commit_i,
  input  logic         pop_i,
  output logic         pending_o,
  output trace_entry_t head_o,
  output logic         drop_o
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  trace_entry_t    mem_q [QueueDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full;
  logic            push;

  assign full      = (count_q == CntW'(QueueDepth));
  assign pending_o = (count_q != '0);
  assign head_o    = mem_q[rd_ptr_q];

  // a pop frees the head slot in the same cycle, so a full queue still accepts
  assign push   = commit_i.retire & (~full | pop_i);
  assign drop_o = commit_i.retire & full & ~pop_i;

  // ------------------------------
  // pointers and fill count
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= commit_i.entry;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // the arbiter must only pop a queue that reported pending
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> pending_o)
    else $error("trace_queue: pop while empty");

  assert property (@(posedge clk_i) disable iff (!rst_ni) count_q <= CntW'(QueueDepth))
    else $error("trace_queue: fill count above depth");

endmodule

/* sim/commit_trace_tb.sv */
module commit_trace_tb import trace_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NrPorts   = 2;
  localparam int unsigned Depth     = 4;
  localparam int unsigned PortW     = (NrPorts > 1) ? $clog2(NrPorts) : 1;
  localparam int unsigned ClkPeriod = 40;
  // per-test budgets 60 + 60 + 60 + 120 + 60 + 140 cycles
  localparam int unsigned BudgetCycles = 500;

  typedef enum int {EV_NONE, EV_RETIRE, EV_EXC, EV_IRQ} event_t;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  logic [NrPorts-1:0]           commit_valid_i;
  logic [NrPorts-1:0]           commit_ex_valid_i;
  logic [NrPorts-1:0][XLEN-1:0] commit_pc_i;
  logic [NrPorts-1:0][ILEN-1:0] commit_insn_i;
  logic [NrPorts-1:0][XLEN-1:0] commit_cause_i;
  priv_lvl_t                    priv_lvl_i;
  logic                         debug_mode_i;
  perf_addr_t                   perf_addr_i;
  logic                         perf_we_i;
  logic [XLEN-1:0]              perf_wdata_i;
  logic [XLEN-1:0]              perf_rdata_o;
  logic                         trace_valid_o;
  logic [PortW-1:0]             trace_port_o;
  logic [XLEN-1:0]              trace_pc_o;
  logic [ILEN-1:0]              trace_insn_o;
  mode_t                        trace_mode_o;

  integer       seed = 32'h294ae73b;
  trace_entry_t model_q [NrPorts][$];
  int           rr_ptr;
  int           traced;
  int           model_ret;
  int           model_drops;
  int           model_exc;
  int           model_irq;
  int           errors;
  int           err_mark;
  int           tests_run;
  int           tests_failed;
  string        cur_test = "reset";
  mode_t        last_mode;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  commit_trace #(
    .NrCommitPorts ( NrPorts ),
    .QueueDepth    ( Depth   )
  ) dut_i (
    .clk_i, .rst_ni, .commit_valid_i, .commit_ex_valid_i, .commit_pc_i, .commit_insn_i,
    .commit_cause_i, .priv_lvl_i, .debug_mode_i, .trace_valid_o, .trace_port_o, .trace_pc_o,
    .trace_insn_o, .trace_mode_o, .perf_addr_i, .perf_we_i, .perf_wdata_i, .perf_rdata_o
  );

  // ------------------------------
  // reference functions
  // ------------------------------
  function automatic mode_t ref_mode(input priv_lvl_t priv, input logic dbg);
    if (dbg) return MODE_D;
    if (priv == PRIV_LVL_M) return MODE_M;
    if (priv == PRIV_LVL_S) return MODE_S;
    return MODE_U;
  endfunction

  function automatic event_t ref_class(input logic valid, input logic ex,
                                       input logic [XLEN-1:0] cause);
    if (!valid) return EV_NONE;
    if (!ex) return EV_RETIRE;
    return cause[63] ? EV_IRQ : EV_EXC;
  endfunction

  // first pending port at or after ptr, -1 when nothing is pending
  function automatic int ref_grant(input int ptr, input logic [NrPorts-1:0] pend);
    int idx;
    for (int off = 0; off < NrPorts; off++) begin
      idx = (ptr + off) % NrPorts;
      if (pend[idx]) return idx;
    end
    return -1;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_entry(input string what, input trace_entry_t exp, input trace_entry_t act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_mode(input string what, input mode_t exp, input mode_t act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_port(input string what, input logic [PortW-1:0] exp,
                            input logic [PortW-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  // ------------------------------
  // queue and arbiter model, compares every cycle
  // ------------------------------
  always @(posedge clk_i) begin : model_step
    int                 g;
    logic [NrPorts-1:0] pend;
    event_t             ev;
    if (!rst_ni) begin
      rr_ptr = 0;
    end else begin
      // every valid cycle on the trace bus, as seen from the DUT
      if (trace_valid_o) begin
        traced++;
      end
      for (int p = 0; p < NrPorts; p++) pend[p] = (model_q[p].size() != 0);
      g = ref_grant(rr_ptr, pend);
      if (g < 0 && trace_valid_o) begin
        errors++;
        $display("%s: trace bus valid while every queue should be empty", cur_test);
      end else if (g >= 0 && !trace_valid_o) begin
        errors++;
        $display("%s: trace bus idle while port %0d holds an entry", cur_test, g);
      end else if (g >= 0) begin
        check_port("trace port", PortW'(g), trace_port_o);
        check_entry("trace entry", model_q[g][0], {trace_pc_o, trace_insn_o, trace_mode_o});
        last_mode = trace_mode_o;
        void'(model_q[g].pop_front());
        rr_ptr = (g + 1) % NrPorts;
      end
      // the pop above frees a slot before the push, as in the queue
      for (int p = 0; p < NrPorts; p++) begin
        ev = ref_class(commit_valid_i[p], commit_ex_valid_i[p], commit_cause_i[p]);
        if (ev == EV_RETIRE) begin
          model_ret++;
          if (model_q[p].size() < Depth) begin
            model_q[p].push_back({commit_pc_i[p], commit_insn_i[p],
                                  ref_mode(priv_lvl_i, debug_mode_i)});
          end else begin
            model_drops++;
          end
        end
        if (ev == EV_EXC) model_exc++;
        if (ev == EV_IRQ) model_irq++;
      end
    end
  end

  // ------------------------------
  // stimulus tasks
  // ------------------------------
  task automatic drive_cycle(input logic [NrPorts-1:0] valid, input logic [NrPorts-1:0] ex,
                             input logic [NrPorts-1:0] irq);
    @(negedge clk_i);
    for (int p = 0; p < NrPorts; p++) begin
      commit_valid_i[p]    = valid[p];
      commit_ex_valid_i[p] = ex[p];
      commit_pc_i[p]       = {32'h8000_0000, $random(seed)} & ~64'h3;
      commit_insn_i[p]     = $random(seed);
      commit_cause_i[p]    = {irq[p], 55'd0, 8'($random(seed))};
    end
  endtask

  // entries still held by the queue model over all ports
  function automatic int queued_entries();
    int n;
    n = 0;
    for (int p = 0; p < NrPorts; p++) begin
      n += model_q[p].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    while (queued_entries() != 0) @(negedge clk_i);
  endtask

  task automatic write_counter(input perf_addr_t addr, input logic [XLEN-1:0] data);
    @(negedge clk_i);
    perf_addr_i  = addr;
    perf_we_i    = 1'b1;
    perf_wdata_i = data;
    @(negedge clk_i);
    perf_we_i = 1'b0;
  endtask

  // read a quarter period after the falling edge, once the mux has settled
  task automatic read_counter(input perf_addr_t addr, output logic [XLEN-1:0] data);
    @(negedge clk_i);
    perf_addr_i = addr;
    #(ClkPeriod / 4);
    data = perf_rdata_o;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", cur_test, errors - err_mark);
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : main
    priv_lvl_t       privs [3];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] wval;
    int              t0;
    int              m0;
    int              m1;
    time             ta;
    privs = '{PRIV_LVL_U, PRIV_LVL_S, PRIV_LVL_M};
    commit_valid_i = '0;
    commit_ex_valid_i = '0;
    commit_pc_i = '0;
    commit_insn_i = '0;
    commit_cause_i = '0;
    priv_lvl_i = PRIV_LVL_M;
    debug_mode_i = 1'b0;
    perf_addr_i = PERF_CYCLE;
    perf_we_i = 1'b0;
    perf_wdata_i = '0;
    rst_ni = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    begin_test("single_port");
    t0 = traced;
    for (int i = 0; i < 8; i++) begin
      drive_cycle(NrPorts'(1), '0, '0);
      drive_cycle('0, '0, '0);
      wait_drain();
    end
    check_count("traced entries", 8, XLEN'(traced - t0));
    end_test();

    begin_test("mode_encoding");
    for (int d = 0; d < 2; d++) begin
      for (int k = 0; k < 3; k++) begin
        priv_lvl_i   = privs[k];
        debug_mode_i = d[0];
        drive_cycle(NrPorts'(1), '0, '0);
        drive_cycle('0, '0, '0);
        wait_drain();
        check_mode("traced mode", ref_mode(privs[k], d[0]), last_mode);
      end
    end
    debug_mode_i = 1'b0;
    end_test();

    begin_test("exceptions");
    read_counter(PERF_EXCEPTION, a);
    read_counter(PERF_INTERRUPT, b);
    t0 = traced;
    m0 = model_exc;
    m1 = model_irq;
    for (int i = 0; i < 20; i++) begin
      drive_cycle(NrPorts'($random(seed)), '1, NrPorts'($random(seed)));
    end
    drive_cycle('0, '0, '0);
    check_count("traced entries", 0, XLEN'(traced - t0));
    read_counter(PERF_EXCEPTION, wval);
    check_count("exception count", XLEN'(model_exc - m0), wval - a);
    read_counter(PERF_INTERRUPT, wval);
    check_count("interrupt count", XLEN'(model_irq - m1), wval - b);
    end_test();

    begin_test("dual_port_bursts");
    read_counter(PERF_DROPPED, a);
    t0 = traced;
    m0 = model_ret;
    for (int i = 0; i < 8; i++) begin
      for (int c = 0; c < 3; c++) drive_cycle(NrPorts'($random(seed)), '0, '0);
      drive_cycle('0, '0, '0);
      wait_drain();
    end
    read_counter(PERF_DROPPED, b);
    check_count("dropped entries", 0, b - a);
    check_count("traced entries", XLEN'(model_ret - m0), XLEN'(traced - t0));
    end_test();

    begin_test("counter_port");
    wval = {$random(seed), $random(seed)};
    write_counter(PERF_INSTRET, wval);
    read_counter(PERF_INSTRET, a);
    check_count("instret after write", wval, a);
    for (int i = 0; i < 3; i++) drive_cycle(NrPorts'(1), '0, '0);
    drive_cycle('0, '0, '0);
    wait_drain();
    read_counter(PERF_INSTRET, a);
    check_count("instret after retires", wval + 3, a);
    for (int u = NR_PERF_COUNTERS; u < 8; u++) begin
      read_counter(perf_addr_t'(u), a);
      check_count("unmapped read", '0, a);
    end
    read_counter(PERF_CYCLE, a);
    ta = $time;
    repeat (7) @(negedge clk_i);
    read_counter(PERF_CYCLE, b);
    check_count("cycle delta", XLEN'(($time - ta) / ClkPeriod), b - a);
    end_test();

    begin_test("overflow");
    write_counter(PERF_INSTRET, '0);
    write_counter(PERF_DROPPED, '0);
    t0 = traced;
    m1 = model_drops;
    for (int i = 0; i < 40; i++) drive_cycle('1, '0, '0);
    drive_cycle('0, '0, '0);
    wait_drain();
    read_counter(PERF_INSTRET, a);
    read_counter(PERF_DROPPED, b);
    check_count("retired count", 80, a);
    check_count("dropped count", XLEN'(model_drops - m1), b);
    check_count("traced plus dropped", 80, XLEN'(traced - t0) + b);
    end_test();

    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(4 * BudgetCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles, the tests did not complete",
             4 * BudgetCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

/* vlog.f */
rtl/trace_pkg.sv
rtl/commit_if.sv
rtl/commit_classify.sv
rtl/trace_queue.sv
rtl/trace_arbiter.sv
rtl/perf_counters.sv
rtl/commit_trace.sv
sim/commit_trace_tb.sv
